//--- verilog.f
rtl/coreCfgPkg.sv
rtl/memBusPkg.sv
rtl/reqQueue.sv
rtl/memArbiter.sv
rtl/memController.sv
rtl/memSubsystem.sv
dv/memSubsystem_chk.sv
dv/memSubsystemTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := memSubsystemTb
FILELIST := verilog.f
BUILD    := obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- dv/memSubsystemTb.sv
module memSubsystemTb;
    localparam int Depth         = coreCfgPkg::DefQueueDepth;
    localparam int Latency       = coreCfgPkg::DefMemLatency;
    localparam int TimeoutCycles = 2000;
    localparam int RandomOps     = 300;

    logic                         clk = 1'b0;
    logic                         rstN;
    logic                         lsuPush;
    logic                         lsuWrite;
    logic [coreCfgPkg::AddrW-1:0] lsuAddr;
    logic [coreCfgPkg::DataW-1:0] lsuData;
    logic                         lsuFull;
    logic                         ccPush;
    logic                         ccWrite;
    logic [coreCfgPkg::AddrW-1:0] ccAddr;
    logic [coreCfgPkg::DataW-1:0] ccData;
    logic                         ccFull;
    logic                         fetchPush;
    logic [coreCfgPkg::AddrW-1:0] fetchAddr;
    logic                         fetchFull;
    logic                         respValid;
    memBusPkg::clientT            respClient;
    logic [coreCfgPkg::DataW-1:0] respData;

    logic [coreCfgPkg::DataW-1:0] shadow [1 << coreCfgPkg::AddrW];
    logic [coreCfgPkg::DataW-1:0] lsuExp [$];
    logic [coreCfgPkg::DataW-1:0] ccExp [$];
    logic [coreCfgPkg::DataW-1:0] fetchExp [$];
    memBusPkg::clientT            respOrder [$];
    int                           acceptQ [$]; // Edge index of each accepted read
    int                           cycle = 0;

    memSubsystem memSubsystem_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic expectBit(input string name, input logic got, input logic exp);
        assert (got === exp)
            else failNow($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    // Updates the shadow memory in push order and returns the word a read sees
    function automatic logic [coreCfgPkg::DataW-1:0] shadowAccess(
        input logic                         write,
        input logic [coreCfgPkg::AddrW-1:0] addr,
        input logic [coreCfgPkg::DataW-1:0] data
    );
        if (write) begin
            shadow[addr] = data;
        end
        return shadow[addr];
    endfunction

    function automatic logic clientFull(input memBusPkg::clientT client);
        case (client)
            memBusPkg::Lsu: return lsuFull;
            memBusPkg::Cc:  return ccFull;
            default:        return fetchFull;
        endcase
    endfunction

    task automatic clearPush();
        lsuPush   = 1'b0;
        ccPush    = 1'b0;
        fetchPush = 1'b0;
    endtask

    task automatic setPush(
        input memBusPkg::clientT            client,
        input logic                         write,
        input logic [coreCfgPkg::AddrW-1:0] addr,
        input logic [coreCfgPkg::DataW-1:0] data
    );
        logic [coreCfgPkg::DataW-1:0] expData;
        expData = shadowAccess(write, addr, data);
        case (client)
            memBusPkg::Lsu: begin
                lsuPush  = 1'b1;
                lsuWrite = write;
                lsuAddr  = addr;
                lsuData  = data;
                if (!write) lsuExp.push_back(expData);
            end
            memBusPkg::Cc: begin
                ccPush  = 1'b1;
                ccWrite = write;
                ccAddr  = addr;
                ccData  = data;
                if (!write) ccExp.push_back(expData);
            end
            default: begin
                fetchPush = 1'b1; // Always a read
                fetchAddr = addr;
                fetchExp.push_back(expData);
            end
        endcase
    endtask

    task automatic issue(
        input memBusPkg::clientT            client,
        input logic                         write,
        input logic [coreCfgPkg::AddrW-1:0] addr,
        input logic [coreCfgPkg::DataW-1:0] data
    );
        int waited;
        waited = 0;
        @(negedge clk);
        clearPush();
        while (clientFull(client)) begin
            if (waited == TimeoutCycles) failNow("timeout waiting for a queue to leave full");
            waited++;
            @(negedge clk);
        end
        setPush(client, write, addr, data);
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        @(negedge clk);
        clearPush();
        while (lsuExp.size() + ccExp.size() + fetchExp.size() != 0) begin
            if (waited == TimeoutCycles) failNow("timeout waiting for outstanding reads");
            waited++;
            @(negedge clk);
        end
    endtask

    // Compares responses and tracks read acceptance for the latency check
    always @(negedge clk) begin
        logic [coreCfgPkg::DataW-1:0] expData;
        int                           latency;
        if (rstN && respValid) begin
            assert (acceptQ.size() != 0) else failNow("response with no accepted read");
            latency = cycle - acceptQ.pop_front();
            assert (latency == Latency) else failNow("read response arrived at the wrong cycle");
            case (respClient)
                memBusPkg::Lsu: begin
                    assert (lsuExp.size() != 0) else failNow("LSU response with no LSU read");
                    expData = lsuExp.pop_front();
                end
                memBusPkg::Cc: begin
                    assert (ccExp.size() != 0) else failNow("cache response with no cache read");
                    expData = ccExp.pop_front();
                end
                memBusPkg::Fetch: begin
                    assert (fetchExp.size() != 0) else failNow("fetch response with no fetch read");
                    expData = fetchExp.pop_front();
                end
                default: failNow("response carries an unknown client tag");
            endcase
            assert (respData == expData)
                else failNow($sformatf("Fail respData: got 0x%h expected 0x%h", respData, expData));
            respOrder.push_back(respClient);
        end
        if (rstN && memSubsystem_i.reqValid && memSubsystem_i.req.cmd == memBusPkg::Read) begin
            acceptQ.push_back(cycle + 1); // Taken at the coming edge
        end
    end

    initial begin
        void'($urandom(94));
        foreach (shadow[i]) shadow[i] = '0;
        rstN     = 1'b0;
        clearPush();
        lsuWrite  = 1'b0;
        lsuAddr   = '0;
        lsuData   = '0;
        ccWrite   = 1'b0;
        ccAddr    = '0;
        ccData    = '0;
        fetchAddr = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        @(negedge clk);
        expectBit("respValid", respValid, 1'b0);
        expectBit("lsuFull", lsuFull, 1'b0);
        expectBit("ccFull", ccFull, 1'b0);
        expectBit("fetchFull", fetchFull, 1'b0);

        // Cache controller fills the fetch region
        for (int i = 0; i < 64; i++) begin
            issue(memBusPkg::Cc, 1'b1, {2'b11, 6'(i)}, $urandom);
        end

        issue(memBusPkg::Lsu, 1'b1, 8'h05, 32'hA5A5_0001);
        issue(memBusPkg::Lsu, 1'b0, 8'h05, '0);
        waitDrain();

        // One read in flight and then all three clients at once
        respOrder.delete();
        setPush(memBusPkg::Lsu, 1'b0, 8'h05, '0);
        @(negedge clk);
        setPush(memBusPkg::Lsu, 1'b0, 8'h06, '0);
        setPush(memBusPkg::Cc, 1'b0, 8'h40, '0);
        setPush(memBusPkg::Fetch, 1'b0, 8'hC3, '0);
        waitDrain();
        assert (respOrder.size() == 4 && respOrder[0] == memBusPkg::Lsu
                && respOrder[1] == memBusPkg::Lsu
                && respOrder[2] == memBusPkg::Cc && respOrder[3] == memBusPkg::Fetch)
            else failNow("responses did not follow client priority");

        for (int i = 0; i < Depth; i++) begin
            @(negedge clk);
            setPush(memBusPkg::Lsu, 1'b0, {2'b00, 6'(i)}, '0);
            setPush(memBusPkg::Fetch, 1'b0, {2'b11, 6'(i + 8)}, '0);
        end
        @(negedge clk);
        clearPush();
        expectBit("fetchFull", fetchFull, 1'b1);
        waitDrain();

        for (int n = 0; n < RandomOps; n++) begin
            case ($urandom % 3)
                0: issue(memBusPkg::Lsu, 1'($urandom), {2'b00, 6'($urandom)}, $urandom);
                1: issue(memBusPkg::Cc, 1'($urandom), {2'b01, 6'($urandom)}, $urandom);
                default: issue(memBusPkg::Fetch, 1'b0, {2'b11, 6'($urandom)}, '0);
            endcase
        end
        waitDrain();

        if (acceptQ.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            failNow("accepted reads left without a response");
        end
    end
endmodule

//--- dv/memSubsystem_chk.sv
module memSubsystem_chk #(
    parameter int MemLatency = coreCfgPkg::DefMemLatency
) (
    input logic clk,
    input logic rstN,
    input logic reqValid,
    input logic busy,
    input logic respValid
);
    int busyCycles;

    // Busy cycles since the last acceptance
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busyCycles <= 0;
        end else if (reqValid) begin
            busyCycles <= 0;
        end else if (busy) begin
            busyCycles <= busyCycles + 1;
        end
    end

    noReqWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        !(reqValid && busy))
        else $error("request on the controller port while busy");

    respPulse: assert property (@(posedge clk) disable iff (!rstN)
        respValid |=> !respValid)
        else $error("respValid high for more than one cycle");

    busyWindow: assert property (@(posedge clk) disable iff (!rstN)
        $fell(busy) |-> busyCycles == MemLatency) // Exact access window
        else $error("busy window differs from the access latency");
endmodule

bind memController memSubsystem_chk #(.MemLatency(MemLatency)) ctrlChk (
    .clk(clk),
    .rstN(rstN),
    .reqValid(reqValid),
    .busy(busy),
    .respValid(respValid)
);

//--- rtl/memSubsystem.sv
module memSubsystem #(
    parameter int QueueDepth = coreCfgPkg::DefQueueDepth,
    parameter int MemLatency = coreCfgPkg::DefMemLatency
) (
    input  logic                         clk,
    input  logic                         rstN,

    input  logic                         lsuPush,
    input  logic                         lsuWrite,
    input  logic [coreCfgPkg::AddrW-1:0] lsuAddr,
    input  logic [coreCfgPkg::DataW-1:0] lsuData,
    output logic                         lsuFull,

    input  logic                         ccPush,
    input  logic                         ccWrite,
    input  logic [coreCfgPkg::AddrW-1:0] ccAddr,
    input  logic [coreCfgPkg::DataW-1:0] ccData,
    output logic                         ccFull,

    input  logic                         fetchPush,
    input  logic [coreCfgPkg::AddrW-1:0] fetchAddr,
    output logic                         fetchFull,

    output logic                         respValid,
    output memBusPkg::clientT            respClient,
    output logic [coreCfgPkg::DataW-1:0] respData
);
    memBusPkg::accessReqT lsuIn;
    memBusPkg::accessReqT ccIn;
    memBusPkg::fetchReqT  fetchIn;

    assign lsuIn.write  = lsuWrite;
    assign lsuIn.addr   = lsuAddr;
    assign lsuIn.data   = lsuData;
    assign ccIn.write   = ccWrite;
    assign ccIn.addr    = ccAddr;
    assign ccIn.data    = ccData;
    assign fetchIn.addr = fetchAddr;

    logic                 lsuValid;
    logic                 lsuPop;
    memBusPkg::accessReqT lsuHead;
    logic                 ccValid;
    logic                 ccPop;
    memBusPkg::accessReqT ccHead;
    logic                 fetchValid;
    logic                 fetchPop;
    memBusPkg::fetchReqT  fetchHead;

    reqQueue #(.payloadT(memBusPkg::accessReqT), .Depth(QueueDepth)) lsuQueue (
        .clk(clk), .rstN(rstN),
        .push(lsuPush), .pushData(lsuIn), .pop(lsuPop),
        .full(lsuFull), .valid(lsuValid), .head(lsuHead)
    );

    reqQueue #(.payloadT(memBusPkg::accessReqT), .Depth(QueueDepth)) ccQueue (
        .clk(clk), .rstN(rstN),
        .push(ccPush), .pushData(ccIn), .pop(ccPop),
        .full(ccFull), .valid(ccValid), .head(ccHead)
    );

    reqQueue #(.payloadT(memBusPkg::fetchReqT), .Depth(QueueDepth)) fetchQueue (
        .clk(clk), .rstN(rstN),
        .push(fetchPush), .pushData(fetchIn), .pop(fetchPop),
        .full(fetchFull), .valid(fetchValid), .head(fetchHead)
    );

    // Shared controller port
    logic              reqValid;
    memBusPkg::memReqT req;
    logic              busy;

    memArbiter arbiter (
        .lsuValid(lsuValid), .lsuHead(lsuHead),
        .ccValid(ccValid), .ccHead(ccHead),
        .fetchValid(fetchValid), .fetchHead(fetchHead),
        .busy(busy),
        .lsuPop(lsuPop), .ccPop(ccPop), .fetchPop(fetchPop),
        .reqValid(reqValid), .req(req)
    );

    memController #(.MemLatency(MemLatency), .MemWords(1 << coreCfgPkg::AddrW)) memCtrl (
        .clk(clk), .rstN(rstN),
        .reqValid(reqValid), .req(req),
        .busy(busy),
        .respValid(respValid), .respClient(respClient), .respData(respData)
    );
endmodule

//--- rtl/memController.sv
module memController #(
    parameter int MemLatency = coreCfgPkg::DefMemLatency,
    parameter int MemWords   = 1 << coreCfgPkg::AddrW
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         reqValid,
    input  memBusPkg::memReqT            req,
    output logic                         busy,
    output logic                         respValid,
    output memBusPkg::clientT            respClient,
    output logic [coreCfgPkg::DataW-1:0] respData
);
    localparam int CntW = (MemLatency > 1) ? $clog2(MemLatency) : 1;

    logic [coreCfgPkg::DataW-1:0] mem [MemWords];
    logic [CntW-1:0]              waitCnt;
    logic                         pendRead;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            respValid <= 1'b0;
            pendRead  <= 1'b0;
            waitCnt   <= '0;
            for (int i = 0; i < MemWords; i++) begin
                mem[i] <= '0;
            end
        end else begin
            respValid <= 1'b0;
            if (reqValid) begin
                busy     <= 1'b1;
                waitCnt  <= CntW'(MemLatency - 1);
                pendRead <= (req.cmd == memBusPkg::Read);
                if (req.cmd == memBusPkg::Write) begin
                    mem[req.addr] <= req.data; // Visible to the next access
                end
            end else if (busy) begin
                if (waitCnt == '0) begin
                    busy      <= 1'b0;
                    respValid <= pendRead; // Writes finish silently
                end else begin
                    waitCnt <= waitCnt - 1'b1;
                end
            end
        end
    end

    // Read word and tag held until the response leaves
    always_ff @(posedge clk) begin
        if (reqValid) begin
            respData   <= mem[req.addr];
            respClient <= req.client;
        end
    end
endmodule

//--- rtl/memArbiter.sv
module memArbiter (
    input  logic                 lsuValid,
    input  memBusPkg::accessReqT lsuHead,
    input  logic                 ccValid,
    input  memBusPkg::accessReqT ccHead,
    input  logic                 fetchValid,
    input  memBusPkg::fetchReqT  fetchHead,
    input  logic                 busy,
    output logic                 lsuPop,
    output logic                 ccPop,
    output logic                 fetchPop,
    output logic                 reqValid,
    output memBusPkg::memReqT    req
);
    function automatic memBusPkg::memReqT fromAccess(
        input memBusPkg::accessReqT head,
        input memBusPkg::clientT    client
    );
        memBusPkg::memReqT r;
        r.cmd    = head.write ? memBusPkg::Write : memBusPkg::Read;
        r.client = client;
        r.addr   = head.addr;
        r.data   = head.data;
        return r;
    endfunction

    always_comb begin
        lsuPop   = 1'b0;
        ccPop    = 1'b0;
        fetchPop = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        req.cmd  = memBusPkg::None;
        // Nothing goes out while an access is in flight
        if (!busy) begin
            if (lsuValid) begin
                reqValid = 1'b1;
                lsuPop   = 1'b1;
                req      = fromAccess(lsuHead, memBusPkg::Lsu);
            end else if (ccValid) begin
                reqValid = 1'b1;
                ccPop    = 1'b1;
                req      = fromAccess(ccHead, memBusPkg::Cc);
            end else if (fetchValid) begin
                reqValid   = 1'b1;
                fetchPop   = 1'b1;
                req.cmd    = memBusPkg::Read; // Fetch never writes
                req.client = memBusPkg::Fetch;
                req.addr   = fetchHead.addr;
            end
        end
    end
endmodule

//--- rtl/reqQueue.sv
module reqQueue #(
    parameter type payloadT = logic,
    parameter int  Depth    = 4
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output logic    full,
    output logic    valid,
    output payloadT head
);
    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    payloadT         entries [Depth];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [CntW-1:0] count;
    logic            doPush;
    logic            doPop;

    // Wrap for depths that are not a power of two
    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doPush = push && !full; // Dropped when full
    assign doPop  = pop && valid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= pushData;
        end
    end

    assign full  = (count == CntW'(Depth));
    assign valid = (count != '0);
    assign head  = entries[rdPtr]; // Oldest entry
endmodule

//--- rtl/memBusPkg.sv
package memBusPkg;

    typedef enum logic [1:0] {
        None  = 2'd0,
        Read  = 2'd1,
        Write = 2'd2
    } memCmdT;

    // Priority order with the highest first
    typedef enum logic [coreCfgPkg::ClientW-1:0] {
        Lsu   = 2'd0,
        Cc    = 2'd1,
        Fetch = 2'd2
    } clientT;

    // LSU and cache controller payload
    typedef struct packed {
        logic                         write;
        logic [coreCfgPkg::AddrW-1:0] addr;
        logic [coreCfgPkg::DataW-1:0] data;
    } accessReqT;

    // Fetch only reads and carries just the address
    typedef struct packed {
        logic [coreCfgPkg::AddrW-1:0] addr;
    } fetchReqT;

    // Request on the shared controller port
    typedef struct packed {
        memCmdT                       cmd;
        clientT                       client;
        logic [coreCfgPkg::AddrW-1:0] addr;
        logic [coreCfgPkg::DataW-1:0] data;
    } memReqT;

endpackage

//--- rtl/coreCfgPkg.sv
package coreCfgPkg;

    // Word address for 256 words of memory
    localparam int AddrW = 8;

    localparam int DataW = 32;

    // LSU, cache controller and instruction fetch
    localparam int NumClients = 3;

    localparam int ClientW = $clog2(NumClients);

    // Per-client queue depth used when the top level is not overridden
    localparam int DefQueueDepth = 4;

    // Controller cycles from acceptance to response
    localparam int DefMemLatency = 3;

endpackage
